/* ldpc_alu.f */
rtl/ldpc_alu_pkg.sv
rtl/int_alu.sv
rtl/ldpc_simd_unit.sv
rtl/result_merge.sv
rtl/alu_req_ctrl.sv
rtl/ldpc_alu_top.sv
testbench/tb_clock_gen.sv
testbench/ldpc_alu_tb.sv

/* rtl/alu_req_ctrl.sv */
`timescale 1ns/1ns

module alu_req_ctrl import ldpc_alu_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      req_i,
    input  alu_op_t   op_i,
    input  xlen_t     operand_a_i,
    input  xlen_t     operand_b_i,
    input  xlen_t     merged_result_i,
    input  logic      branch_taken_i,
    output alu_op_t   cap_op_o,
    output alu_word_u cap_a_o,
    output alu_word_u cap_b_o,
    output logic      ack_o,
    output xlen_t     result_o,
    output logic      branch_o
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_EXEC = 2'd1;
    localparam logic [1:0] S_ACK  = 2'd2;

    logic [1:0] state_q;
    logic [1:0] state_d;

    // --------------------
    // Handshake FSM
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_i) begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC: state_d = S_ACK;
            // Hold ack until the requester lets go
            S_ACK: begin
                if (!req_i) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign ack_o = (state_q == S_ACK);

    // Operand capture on the accepting edge
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && req_i) begin
            cap_op_o     <= op_i;
            cap_a_o.word <= operand_a_i;
            cap_b_o.word <= operand_b_i;
        end
    end

    // Result registers, loaded one edge after capture
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
            branch_o <= 1'b0;
        end else if (state_q == S_EXEC) begin
            result_o <= merged_result_i;
            branch_o <= branch_taken_i;
        end
    end

    // --------------------
    // Protocol checks
    // --------------------
    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(ack_o) |-> $past(req_i))
        else $error("ack_o rose without a pending request");

    a_op_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_q == S_IDLE && req_i) |-> !$isunknown(op_i))
        else $error("op_i unknown on an accepted request");

endmodule

/* rtl/int_alu.sv */
`timescale 1ns/1ns

module int_alu import ldpc_alu_pkg::*; (
    input  alu_op_t   op_i,
    input  alu_word_u a_i,
    input  alu_word_u b_i,
    output xlen_t     result_o,
    output logic      branch_o
);

    // --------------------
    // Adder
    // --------------------
    logic          negate_b;
    logic [XLEN:0] adder_in_a;
    logic [XLEN:0] adder_in_b;
    logic [XLEN:0] adder_sum;
    xlen_t         adder_res;
    logic          adder_zero;

    // Subtract and equality share the inverted b path
    assign negate_b = op_i inside {SUB, SUBW, EQ, NE};

    // Extra LSB carries the +1 of the two's complement
    assign adder_in_a = {a_i.word, 1'b1};
    assign adder_in_b = {b_i.word, 1'b0} ^ {(XLEN+1){negate_b}};
    assign adder_sum  = adder_in_a + adder_in_b;
    assign adder_res  = adder_sum[XLEN:1];
    assign adder_zero = ~|adder_res;

    // --------------------
    // Shifter
    // --------------------
    logic          shift_left;
    logic          shift_arith;
    xlen_t         shift_in;
    logic [31:0]   shift_in32;
    logic [XLEN:0] shr_ext;
    logic [32:0]   shr_ext32;
    xlen_t         shift_res;
    logic [31:0]   shift_res32;

    assign shift_left  = (op_i == SLL) || (op_i == SLLW);
    assign shift_arith = (op_i == SRA) || (op_i == SRAW);

    // Left shifts go through the right shifter on reversed bits
    assign shift_in   = shift_left ? {<<{a_i.word}} : a_i.word;
    assign shift_in32 = shift_left ? {<<{a_i.word[31:0]}} : a_i.word[31:0];

    assign shr_ext   = $unsigned($signed({shift_arith & shift_in[XLEN-1], shift_in})
                                 >>> b_i.word[5:0]);
    assign shr_ext32 = $unsigned($signed({shift_arith & shift_in32[31], shift_in32})
                                 >>> b_i.word[4:0]);

    assign shift_res   = shift_left ? {<<{shr_ext[XLEN-1:0]}} : shr_ext[XLEN-1:0];
    assign shift_res32 = shift_left ? {<<{shr_ext32[31:0]}} : shr_ext32[31:0];

    // --------------------
    // Comparator
    // --------------------
    logic signed_cmp;
    logic less;

    assign signed_cmp = op_i inside {SLTS, LTS, GES};
    assign less = $signed({signed_cmp & a_i.word[XLEN-1], a_i.word})
                < $signed({signed_cmp & b_i.word[XLEN-1], b_i.word});

    // --------------------
    // Result select
    // --------------------
    always_comb begin
        result_o = '0;
        case (op_i)
            ADD, SUB:         result_o = adder_res;
            // Word forms keep the low half and sign-extend bit 31
            ADDW, SUBW:       result_o = {{(XLEN-32){adder_res[31]}}, adder_res[31:0]};
            AND_L:            result_o = a_i.word & b_i.word;
            OR_L:             result_o = a_i.word | b_i.word;
            XOR_L:            result_o = a_i.word ^ b_i.word;
            SLL, SRL, SRA:    result_o = shift_res;
            SLLW, SRLW, SRAW: result_o = {{(XLEN-32){shift_res32[31]}}, shift_res32};
            SLTS, SLTU:       result_o = {{(XLEN-1){1'b0}}, less};
            default:          result_o = '0;
        endcase
    end

    // Branch outcome, taken by default
    always_comb begin
        case (op_i)
            EQ:       branch_o = adder_zero;
            NE:       branch_o = ~adder_zero;
            LTS, LTU: branch_o = less;
            GES, GEU: branch_o = ~less;
            default:  branch_o = 1'b1;
        endcase
    end

    // Zero flag of a - b must match a direct equality test
    always_comb begin
        if (op_i == EQ || op_i == NE) begin
            assert final (adder_zero == (a_i.word == b_i.word))
                else $error("adder zero flag disagrees with operand compare");
        end
    end

endmodule

/* rtl/ldpc_alu_pkg.sv */
package ldpc_alu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN      = 64;
    localparam int LANE_W    = 8;
    localparam int MAX_LANES = XLEN / LANE_W;

    // Symmetric clamp that never yields -128 from saturation
    localparam int SAT_MAX   = 127;

    typedef logic [XLEN-1:0] xlen_t;

    // --------------------
    // Operations
    // --------------------
    typedef enum logic [4:0] {
        // Adder
        ADD,
        SUB,
        ADDW,
        SUBW,
        // Logic
        AND_L,
        OR_L,
        XOR_L,
        // Shifts
        SLL,
        SRL,
        SRA,
        SLLW,
        SRLW,
        SRAW,
        // Set-less-than
        SLTS,
        SLTU,
        // Branch resolution only
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // LDPC lane ops
        LDPC_SUB_SAT,
        LDPC_ABS,
        LDPC_MAX,
        LDPC_MIN,
        LDPC_EVAL,
        LDPC_RSIGN,
        LDPC_NMESS,
        LDPC_ADD_SAT
    } alu_op_t;

    // --------------------
    // Operand word
    // --------------------
    // Scalar view for the integer path, lane view for the LDPC path
    // Lane 0 sits in bits 7:0
    typedef union packed {
        xlen_t                                   word;
        logic signed [MAX_LANES-1:0][LANE_W-1:0] lanes;
    } alu_word_u;

endpackage

/* rtl/ldpc_alu_top.sv */
`timescale 1ns/1ns

module ldpc_alu_top import ldpc_alu_pkg::*; #(
    parameter int SIMD_LANES = 8
) (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    req_i,
    input  alu_op_t op_i,
    input  xlen_t   operand_a_i,
    input  xlen_t   operand_b_i,
    output logic    ack_o,
    output xlen_t   result_o,
    output logic    branch_o
);

    alu_op_t   cap_op;
    alu_word_u cap_a;
    alu_word_u cap_b;
    xlen_t     int_result;
    logic      branch_taken;
    alu_word_u ldpc_result;
    xlen_t     merged_result;

    // Handshake, capture and result registers
    alu_req_ctrl u_req_ctrl (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .req_i           (req_i),
        .op_i            (op_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .merged_result_i (merged_result),
        .branch_taken_i  (branch_taken),
        .cap_op_o        (cap_op),
        .cap_a_o         (cap_a),
        .cap_b_o         (cap_b),
        .ack_o           (ack_o),
        .result_o        (result_o),
        .branch_o        (branch_o)
    );

    // The two datapaths see the same captured operands
    int_alu u_int_alu (
        .op_i     (cap_op),
        .a_i      (cap_a),
        .b_i      (cap_b),
        .result_o (int_result),
        .branch_o (branch_taken)
    );

    ldpc_simd_unit #(
        .SIMD_LANES (SIMD_LANES)
    ) u_ldpc_simd (
        .op_i     (cap_op),
        .a_i      (cap_a),
        .b_i      (cap_b),
        .result_o (ldpc_result)
    );

    result_merge u_merge (
        .op_i          (cap_op),
        .int_result_i  (int_result),
        .ldpc_result_i (ldpc_result),
        .result_o      (merged_result)
    );

endmodule

/* rtl/ldpc_simd_unit.sv */
`timescale 1ns/1ns

module ldpc_simd_unit import ldpc_alu_pkg::*; #(
    parameter int SIMD_LANES = 8
) (
    input  alu_op_t   op_i,
    input  alu_word_u a_i,
    input  alu_word_u b_i,
    output alu_word_u result_o
);

    if (SIMD_LANES < 1 || SIMD_LANES > MAX_LANES) begin : g_lane_check
        $error("SIMD_LANES must lie between 1 and MAX_LANES");
    end

    // Clamp a 9-bit sum to +/- SAT_MAX
    function automatic logic signed [LANE_W-1:0] saturate(
        input logic signed [LANE_W:0] v
    );
        logic signed [LANE_W-1:0] res;
        if (v > SAT_MAX) begin
            res = SAT_MAX[LANE_W-1:0];
        end else if (v < -SAT_MAX) begin
            res = -SAT_MAX[LANE_W-1:0];
        end else begin
            res = v[LANE_W-1:0];
        end
        return res;
    endfunction

    // --------------------
    // One lane
    // --------------------
    function automatic logic signed [LANE_W-1:0] lane_op(
        input alu_op_t                  op,
        input logic signed [LANE_W-1:0] a,
        input logic signed [LANE_W-1:0] b
    );
        logic signed [LANE_W:0]   sum;
        logic signed [LANE_W:0]   dif;
        logic signed [LANE_W-1:0] res;
        // Widened to 9 bits so overflow is visible
        sum = a + b;
        dif = a - b;
        case (op)
            LDPC_SUB_SAT: res = saturate(dif);
            LDPC_ADD_SAT: res = saturate(sum);
            // -128 wraps back onto itself
            LDPC_ABS:     res = (a < 0) ? -a : a;
            LDPC_MAX:     res = (a >= b) ? a : b;
            LDPC_MIN:     res = (a >= b) ? b : a;
            LDPC_EVAL:    res = (a == b) ? 8'hff : 8'h00;
            LDPC_RSIGN:   res = (b >= 0) ? (a ^ 8'h01) : a;
            LDPC_NMESS:   res = (a != 0) ? b : -b;
            default:      res = '0;
        endcase
        return res;
    endfunction

    // Lanes past SIMD_LANES stay zero
    always_comb begin
        result_o = '0;
        for (int i = 0; i < SIMD_LANES; i++) begin
            result_o.lanes[i] = lane_op(op_i, a_i.lanes[i], b_i.lanes[i]);
        end
    end

    // Saturating ops never reach -128 in any active lane
    always_comb begin : sat_check
        logic in_range;
        in_range = 1'b1;
        for (int i = 0; i < SIMD_LANES; i++) begin
            if ($signed(result_o.lanes[i]) < -SAT_MAX ||
                $signed(result_o.lanes[i]) > SAT_MAX) begin
                in_range = 1'b0;
            end
        end
        if (op_i == LDPC_ADD_SAT || op_i == LDPC_SUB_SAT) begin
            assert final (in_range)
                else $error("saturated lane result outside +/- SAT_MAX");
        end
    end

endmodule

/* rtl/result_merge.sv */
`timescale 1ns/1ns

module result_merge import ldpc_alu_pkg::*; (
    input  alu_op_t   op_i,
    input  xlen_t     int_result_i,
    input  alu_word_u ldpc_result_i,
    output xlen_t     result_o
);

    logic is_ldpc;
    logic is_branch;

    // --------------------
    // Classify the op
    // --------------------
    assign is_ldpc = op_i inside {
        LDPC_SUB_SAT, LDPC_ABS, LDPC_MAX, LDPC_MIN,
        LDPC_EVAL, LDPC_RSIGN, LDPC_NMESS, LDPC_ADD_SAT
    };

    // Branch ops only produce the flag
    assign is_branch = op_i inside {EQ, NE, LTS, LTU, GES, GEU};

    // --------------------
    // Output word
    // --------------------
    always_comb begin
        if (is_ldpc) begin
            result_o = ldpc_result_i.word;
        end else if (is_branch) begin
            result_o = '0;
        end else begin
            result_o = int_result_i;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench and RTL with Verilator, then run the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module ldpc_alu_tb -f ldpc_alu.f -o ldpc_alu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/ldpc_alu_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

/* testbench/ldpc_alu_tb.sv */
`timescale 1ns/1ns

module ldpc_alu_tb import ldpc_alu_pkg::*; ();

    localparam int LANES      = 6;
    localparam int WAIT_LIMIT = 20;

    // Named after the DUT ports
    logic    clk_i;
    logic    arst_n_i;
    logic    req_i;
    alu_op_t op_i;
    xlen_t   operand_a_i;
    xlen_t   operand_b_i;
    logic    ack_o;
    xlen_t   result_o;
    logic    branch_o;

    int      errors;
    bit      aborted;
    integer  seed;
    alu_op_t ops_q[$];
    xlen_t   a_q[$];
    xlen_t   b_q[$];

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(10)) u_clk_gen (
        .clk_o    (clk_i),
        .arst_n_o (arst_n_i)
    );

    ldpc_alu_top #(.SIMD_LANES(LANES)) UUT (.*);

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [7:0] lane_ref(alu_op_t o, logic [7:0] a8, logic [7:0] b8);
        int a;
        int b;
        int s;
        int v;
        a = $signed(a8);
        b = $signed(b8);
        s = (o == LDPC_ADD_SAT) ? a + b : a - b;
        case (o)
            LDPC_SUB_SAT, LDPC_ADD_SAT: v = (s > 127) ? 127 : ((s < -127) ? -127 : s);
            LDPC_ABS:   v = (a < 0) ? -a : a;
            LDPC_MAX:   v = (a > b) ? a : b;
            LDPC_MIN:   v = (a < b) ? a : b;
            LDPC_EVAL:  v = (a == b) ? 255 : 0;
            LDPC_RSIGN: v = (b >= 0) ? (a ^ 1) : a;
            LDPC_NMESS: v = (a != 0) ? b : -b;
            default:    v = 0;
        endcase
        return v[7:0];
    endfunction

    function automatic xlen_t ref_result(alu_op_t o, xlen_t a, xlen_t b);
        logic [31:0] w;
        xlen_t       r;
        w = '0;
        r = '0;
        case (o)
            ADD:   r = a + b;
            SUB:   r = a - b;
            ADDW:  w = a[31:0] + b[31:0];
            SUBW:  w = a[31:0] - b[31:0];
            AND_L: r = a & b;
            OR_L:  r = a | b;
            XOR_L: r = a ^ b;
            SLL:   r = a << b[5:0];
            SRL:   r = a >> b[5:0];
            SRA:   r = $signed(a) >>> b[5:0];
            SLLW:  w = a[31:0] << b[4:0];
            SRLW:  w = a[31:0] >> b[4:0];
            SRAW:  w = $signed(a[31:0]) >>> b[4:0];
            SLTS:  r = {63'd0, $signed(a) < $signed(b)};
            SLTU:  r = {63'd0, a < b};
            // Branch ops leave the word at zero
            default: begin
                if (o >= LDPC_SUB_SAT) begin
                    for (int i = 0; i < LANES; i++) begin
                        r[8*i +: 8] = lane_ref(o, a[8*i +: 8], b[8*i +: 8]);
                    end
                end
            end
        endcase
        if (o inside {ADDW, SUBW, SLLW, SRLW, SRAW}) begin
            r = {{32{w[31]}}, w};
        end
        return r;
    endfunction

    function automatic logic ref_branch(alu_op_t o, xlen_t a, xlen_t b);
        case (o)
            EQ:      return a == b;
            NE:      return a != b;
            LTS:     return $signed(a) < $signed(b);
            LTU:     return a < b;
            GES:     return $signed(a) >= $signed(b);
            GEU:     return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // --------------------
    // Transactions
    // --------------------
    task automatic check_true(input bit ok, input string what);
        assert (ok) else begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic wait_ack(input logic level, output int edges);
        edges = 0;
        while (ack_o !== level && edges < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            edges++;
        end
        if (ack_o !== level) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: ack_o did not reach %b within %0d cycles", level, WAIT_LIMIT);
        end
    endtask

    // Full four-phase exchange, entered 1 ns after an edge
    task automatic run_op(input alu_op_t o, input xlen_t a, input xlen_t b, input int hold);
        xlen_t exp_res;
        logic  exp_br;
        int    edges;
        string tag;
        if (aborted) begin
            return;
        end
        exp_res = ref_result(o, a, b);
        exp_br  = ref_branch(o, a, b);
        tag = $sformatf("%s a=%h b=%h", o.name(), a, b);
        op_i        = o;
        operand_a_i = a;
        operand_b_i = b;
        req_i       = 1'b1;
        wait_ack(1'b1, edges);
        if (aborted) begin
            return;
        end
        check_true(edges == 2, $sformatf("%s ack_o rose after %0d edges", tag, edges));
        // Outputs must stay put while req_i is held
        for (int c = 0; c <= hold; c++) begin
            if (c > 0) begin
                @(posedge clk_i);
                #1;
            end
            check_true(ack_o === 1'b1 && result_o === exp_res && branch_o === exp_br,
                       $sformatf("%s cycle %0d ack %b result %h branch %b, expected %h %b",
                                 tag, c, ack_o, result_o, branch_o, exp_res, exp_br));
        end
        req_i = 1'b0;
        wait_ack(1'b0, edges);
        if (!aborted) begin
            check_true(edges == 1, $sformatf("%s ack_o fell after %0d edges", tag, edges));
        end
    endtask

    task automatic run_sweep();
        foreach (ops_q[i]) begin
            foreach (a_q[j]) begin
                run_op(ops_q[i], a_q[j], b_q[j], 0);
            end
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_handshake();
        check_true(ack_o === 1'b0 && result_o === '0 && branch_o === 1'b0,
                   "outputs not cleared after reset");
        run_op(ADD, 64'd5, 64'd7, 0);
        // Back-pressure for several cycles
        run_op(SUB, rand64(), rand64(), 5);
    endtask

    task automatic test_adder_logic();
        ops_q = {ADD, SUB, ADDW, SUBW, AND_L, OR_L, XOR_L};
        a_q   = {64'd0, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
                 64'h0000_0000_7fff_ffff, 64'h7fff_ffff_ffff_ffff};
        b_q   = {64'hffff_ffff_ffff_ffff, 64'd1, 64'd1, 64'd1, 64'h8000_0000_0000_0000};
        for (int k = 0; k < 4; k++) begin
            a_q.push_back(rand64());
            b_q.push_back(rand64());
        end
        run_sweep();
    endtask

    task automatic test_shifts();
        xlen_t vals [3];
        int    amts [5];
        vals  = '{64'hffff_ffff_8765_4321, 64'h8000_0000_0000_0001, 64'h0123_4567_89ab_cdef};
        amts  = '{0, 1, 31, 32, 63};
        ops_q = {SLL, SRL, SRA, SLLW, SRLW, SRAW};
        a_q.delete();
        b_q.delete();
        foreach (vals[j]) begin
            foreach (amts[k]) begin
                a_q.push_back(vals[j]);
                // Upper amount bits are don't-care
                b_q.push_back(64'hab00 | 64'(amts[k]));
            end
        end
        run_sweep();
    endtask

    task automatic test_compare();
        // OR_L as a non-branch op with branch_o high
        ops_q = {SLTS, SLTU, EQ, NE, LTS, LTU, GES, GEU, OR_L};
        a_q   = {64'hffff_ffff_ffff_ffff, 64'd5, 64'h8000_0000_0000_0000, 64'd42, 64'd7};
        b_q   = {64'd1, 64'hffff_ffff_ffff_fffb, 64'h7fff_ffff_ffff_ffff, 64'd42, 64'd9};
        run_sweep();
    endtask

    task automatic test_ldpc();
        logic [7:0] corner [8];
        xlen_t      a;
        xlen_t      b;
        corner = '{8'h7f, 8'h81, 8'h80, 8'h00, 8'h01, 8'hff, 8'h7f, 8'h80};
        ops_q  = {LDPC_SUB_SAT, LDPC_ABS, LDPC_MAX, LDPC_MIN,
                  LDPC_EVAL, LDPC_RSIGN, LDPC_NMESS, LDPC_ADD_SAT};
        a_q.delete();
        b_q.delete();
        // Rotating b meets every corner pair
        // Lanes 6 and 7 carry data but must read zero
        for (int r = 0; r < 8; r++) begin
            for (int l = 0; l < MAX_LANES; l++) begin
                a[8*l +: 8] = corner[l];
                b[8*l +: 8] = corner[(l + r) % 8];
            end
            a_q.push_back(a);
            b_q.push_back(b);
        end
        a_q.push_back(rand64());
        b_q.push_back(rand64());
        run_sweep();
    endtask

    task automatic report_and_finish();
        $display("Summary: %0d errors", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial begin
        int cycles;
        seed        = 32'h79a4;
        errors      = 0;
        aborted     = 1'b0;
        req_i       = 1'b0;
        op_i        = ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        cycles      = 0;
        while (arst_n_i !== 1'b1 && cycles < 40) begin
            @(posedge clk_i);
            cycles++;
        end
        if (arst_n_i !== 1'b1) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: reset was never released");
        end
        @(posedge clk_i);
        #1;
        test_handshake();
        test_adder_logic();
        test_shifts();
        test_compare();
        test_ldpc();
        report_and_finish();
    end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // Release 1 ns after an edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule
